// File: common/nor_pkg.sv
package nor_pkg;

    // bus widths
    localparam int cmd_bits        = 6;
    localparam int addr_bits       = 26;
    localparam int data_bits       = 16;
    // unlock addresses are only 12 bits wide on the flash side
    localparam int table_addr_bits = 12;

    // longest unlock sequence, in bus cycles
    localparam int max_cycles      = 6;
    localparam int cycle_idx_bits  = 3;

    // command codes, carried in the top bits of the slave address
    localparam logic [cmd_bits-1:0] cmd_read         = 6'd0;
    localparam logic [cmd_bits-1:0] cmd_cfi_enter    = 6'd1;
    localparam logic [cmd_bits-1:0] cmd_program      = 6'd2;
    localparam logic [cmd_bits-1:0] cmd_erase_sector = 6'd3;
    localparam logic [cmd_bits-1:0] cmd_erase_chip   = 6'd4;
    localparam logic [cmd_bits-1:0] cmd_reset        = 6'd5;
    // anything above this is rejected with err
    localparam logic [cmd_bits-1:0] cmd_max_valid    = 6'd5;

    // bus cycles per command, indexed by code
    localparam logic [cycle_idx_bits-1:0] cycle_count [0:cmd_max_valid] = '{
        3'd1,   // read
        3'd1,   // cfi enter
        3'd4,   // program
        3'd6,   // sector erase
        3'd6,   // chip erase
        3'd1    // reset
    };

    // standard two-word unlock prefix
    localparam logic [table_addr_bits-1:0] unlock_adr_1 = 12'h555;
    localparam logic [table_addr_bits-1:0] unlock_adr_2 = 12'h2AA;
    localparam logic [data_bits-1:0]       unlock_dat_1 = 16'h00AA;
    localparam logic [data_bits-1:0]       unlock_dat_2 = 16'h0055;

    // slave address word: code above flash address
    typedef struct packed {
        logic [cmd_bits-1:0]  code;
        logic [addr_bits-1:0] addr;
    } nor_cmd_t;

    // latched request, latch to sequencer
    typedef struct packed {
        nor_cmd_t             cmd;
        logic [data_bits-1:0] data;
    } nor_req_t;

    // one flash bus cycle, sequencer to master
    typedef struct packed {
        logic [addr_bits-1:0] adr;
        logic [data_bits-1:0] dat;
        logic                 we;
    } nor_bus_req_t;

    // one row of the unlock table
    typedef struct packed {
        logic [table_addr_bits-1:0] fixed_adr;
        logic [data_bits-1:0]       fixed_dat;
        logic                       use_addr;   // take slave address instead
        logic                       use_data;   // take slave data instead
    } nor_cycle_entry_t;

endpackage

// File: list.f
common/nor_pkg.sv
src/nor_req_latch.sv
nor_seq/nor_cycle_table.sv
nor_seq/nor_cycle_sequencer.sv
src/nor_bus_master.sv
src/nor_controller.sv
test/tb_clock_gen.sv
test/tb_nor_controller.sv

// File: nor_seq/nor_cycle_sequencer.sv
`timescale 1ns/1ns

module nor_cycle_sequencer (
    input  logic                          wb_clk_i,
    input  logic                          mod_reset_i,
    input  nor_pkg::nor_req_t             req_i,
    input  logic                          start_i,
    input  logic                          bus_done_i,
    input  logic [nor_pkg::data_bits-1:0] bus_rdata_i,
    output logic                          bus_go_o,
    output nor_pkg::nor_bus_req_t         bus_req_o,
    output logic                          done_o,
    output logic [nor_pkg::data_bits-1:0] rdata_o
);

    logic                               busy;
    logic [nor_pkg::cycle_idx_bits-1:0] cycle_idx;
    logic [nor_pkg::cycle_idx_bits-1:0] cycle_cnt;
    logic [nor_pkg::cycle_idx_bits-1:0] next_idx;
    logic [nor_pkg::cycle_idx_bits-1:0] tbl_cycle;
    logic                               last_cycle;
    logic                               is_read;
    logic                               advance;
    nor_pkg::nor_cycle_entry_t          entry;
    nor_pkg::nor_bus_req_t              next_req;

    assign next_idx   = cycle_idx + 3'd1;
    assign last_cycle = next_idx == cycle_cnt;
    assign is_read    = req_i.cmd.code == nor_pkg::cmd_read;

    // more cycles to go after this bus_done
    assign advance = busy && bus_done_i && !last_cycle;

    // look up the row for the cycle about to be issued
    assign tbl_cycle = start_i ? '0 : next_idx;

    nor_cycle_table table_i (
        .code_i  (req_i.cmd.code),
        .cycle_i (tbl_cycle),
        .entry_o (entry)
    );

    // fixed row value or the caller's address/data
    always_comb begin
        next_req.adr = {{(nor_pkg::addr_bits - nor_pkg::table_addr_bits){1'b0}},
                        entry.fixed_adr};
        if (entry.use_addr) begin
            next_req.adr = req_i.cmd.addr;
        end
        next_req.dat = entry.use_data ? req_i.data : entry.fixed_dat;
        next_req.we  = !is_read;
    end

    always_ff @(posedge wb_clk_i) begin
        if (mod_reset_i) begin
            busy      <= 1'b0;
            cycle_idx <= '0;
            cycle_cnt <= '0;
            bus_go_o  <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            bus_go_o <= 1'b0;
            done_o   <= 1'b0;
            if (start_i) begin
                busy      <= 1'b1;
                cycle_idx <= '0;
                // latch only starts us on a valid code
                cycle_cnt <= nor_pkg::cycle_count[req_i.cmd.code[2:0]];
                bus_go_o  <= 1'b1;
            end else if (advance) begin
                cycle_idx <= next_idx;
                bus_go_o  <= 1'b1;
            end else if (busy && bus_done_i) begin
                // last bus cycle back, ack the slave
                busy      <= 1'b0;
                cycle_idx <= '0;
                done_o    <= 1'b1;
            end
        end
    end

    // payload
    always_ff @(posedge wb_clk_i) begin
        if (start_i || advance) begin
            bus_req_o <= next_req;
        end
        // read data only moves with the ack of a read
        if (busy && bus_done_i && last_cycle && is_read) begin
            rdata_o <= bus_rdata_i;
        end
    end

    a_idx_in_range : assert property (@(posedge wb_clk_i) disable iff (mod_reset_i)
        busy |-> cycle_idx < cycle_cnt);

endmodule

// File: nor_seq/nor_cycle_table.sv
`timescale 1ns/1ns

module nor_cycle_table (
    input  logic [nor_pkg::cmd_bits-1:0]       code_i,
    input  logic [nor_pkg::cycle_idx_bits-1:0] cycle_i,
    output nor_pkg::nor_cycle_entry_t          entry_o
);

    logic [nor_pkg::cycle_idx_bits-1:0] cnt;

    // sequence length; zero for bad codes so every row blanks out
    always_comb begin
        cnt = '0;
        if (code_i <= nor_pkg::cmd_max_valid) begin
            // valid codes fit in the low 3 bits
            cnt = nor_pkg::cycle_count[code_i[2:0]];
        end
    end

    always_comb begin
        entry_o = '0;
        case (code_i)
            nor_pkg::cmd_read: begin
                // single read at the caller's address
                entry_o.use_addr = 1'b1;
            end
            nor_pkg::cmd_cfi_enter: begin
                entry_o.fixed_adr = 12'h055;
                entry_o.fixed_dat = 16'h0098;
            end
            nor_pkg::cmd_program: begin
                case (cycle_i)
                    3'd0: begin
                        entry_o.fixed_adr = nor_pkg::unlock_adr_1;
                        entry_o.fixed_dat = nor_pkg::unlock_dat_1;
                    end
                    3'd1: begin
                        entry_o.fixed_adr = nor_pkg::unlock_adr_2;
                        entry_o.fixed_dat = nor_pkg::unlock_dat_2;
                    end
                    3'd2: begin
                        entry_o.fixed_adr = nor_pkg::unlock_adr_1;
                        entry_o.fixed_dat = 16'h00A0;
                    end
                    default: begin
                        // program word goes straight to its own address
                        entry_o.use_addr = 1'b1;
                        entry_o.use_data = 1'b1;
                    end
                endcase
            end
            nor_pkg::cmd_erase_sector, nor_pkg::cmd_erase_chip: begin
                case (cycle_i)
                    3'd0, 3'd3: begin
                        entry_o.fixed_adr = nor_pkg::unlock_adr_1;
                        entry_o.fixed_dat = nor_pkg::unlock_dat_1;
                    end
                    3'd1, 3'd4: begin
                        entry_o.fixed_adr = nor_pkg::unlock_adr_2;
                        entry_o.fixed_dat = nor_pkg::unlock_dat_2;
                    end
                    3'd2: begin
                        entry_o.fixed_adr = nor_pkg::unlock_adr_1;
                        entry_o.fixed_dat = 16'h0080;
                    end
                    default: begin
                        // last word differs: sector address + 30, or 555 + 10
                        if (code_i == nor_pkg::cmd_erase_sector) begin
                            entry_o.use_addr  = 1'b1;
                            entry_o.fixed_dat = 16'h0030;
                        end else begin
                            entry_o.fixed_adr = nor_pkg::unlock_adr_1;
                            entry_o.fixed_dat = 16'h0010;
                        end
                    end
                endcase
            end
            nor_pkg::cmd_reset: begin
                entry_o.fixed_dat = 16'h00F0;
            end
            default: ;
        endcase
        // past the end of the sequence
        if (cycle_i >= cnt) begin
            entry_o = '0;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_nor_controller \
    -Mdir obj_dir -o sim_nor
./obj_dir/sim_nor > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
grep -q "Done: no errors" sim.log

// File: src/nor_bus_master.sv
`timescale 1ns/1ns

module nor_bus_master (
    input  logic                          wb_clk_i,
    input  logic                          mod_reset_i,
    input  logic                          go_i,
    input  nor_pkg::nor_bus_req_t         req_i,
    input  logic                          wbm_ack_i,
    input  logic [nor_pkg::data_bits-1:0] wbm_dat_i,
    input  logic                          wbm_stall_i,
    output logic [nor_pkg::addr_bits-1:0] wbm_adr_o,
    output logic [nor_pkg::data_bits-1:0] wbm_dat_o,
    output logic                          wbm_we_o,
    output logic                          wbm_stb_o,
    output logic                          wbm_cyc_o,
    output logic                          done_o,
    output logic [nor_pkg::data_bits-1:0] rdata_o
);

    logic pending;
    logic cycle_end;

    assign cycle_end = wbm_cyc_o && wbm_ack_i;

    always_ff @(posedge wb_clk_i) begin
        if (mod_reset_i) begin
            pending   <= 1'b0;
            wbm_cyc_o <= 1'b0;
            wbm_stb_o <= 1'b0;
            wbm_we_o  <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            // strobe is a single cycle
            wbm_stb_o <= 1'b0;
            done_o    <= 1'b0;
            if (go_i) begin
                pending  <= 1'b1;
                wbm_we_o <= req_i.we;
            end else if (pending && !wbm_stall_i) begin
                // slave ready, launch
                pending   <= 1'b0;
                wbm_cyc_o <= 1'b1;
                wbm_stb_o <= 1'b1;
            end else if (cycle_end) begin
                wbm_cyc_o <= 1'b0;
                wbm_we_o  <= 1'b0;
                done_o    <= 1'b1;
            end
        end
    end

    // address/data held from go until the next go
    always_ff @(posedge wb_clk_i) begin
        if (go_i) begin
            wbm_adr_o <= req_i.adr;
            wbm_dat_o <= req_i.dat;
        end
        if (cycle_end) begin
            rdata_o <= wbm_dat_i;
        end
    end

    a_stb_in_cyc : assert property (@(posedge wb_clk_i) wbm_stb_o |-> wbm_cyc_o);

    // back-pressure must not disturb the waiting request
    a_stall_stable : assert property (@(posedge wb_clk_i) disable iff (mod_reset_i)
        pending && wbm_stall_i |=> $stable({wbm_adr_o, wbm_dat_o, wbm_we_o}));

endmodule

// File: src/nor_controller.sv
`timescale 1ns/1ns

module nor_controller (
    input  logic                          wb_clk_i,
    input  logic                          wb_rst_i,
    input  nor_pkg::nor_cmd_t             wbs_adr_i,
    input  logic [nor_pkg::data_bits-1:0] wbs_dat_i,
    // direction comes from the command code, so we is not looked at
    input  logic                          wbs_we_i,
    input  logic                          wbs_stb_i,
    input  logic                          wbs_cyc_i,
    output logic                          wbs_err_o,
    output logic                          wbs_ack_o,
    output logic [nor_pkg::data_bits-1:0] wbs_dat_o,
    output logic                          wbs_stall_o,
    output logic [nor_pkg::addr_bits-1:0] wbm_adr_o,
    output logic [nor_pkg::data_bits-1:0] wbm_dat_o,
    output logic                          wbm_we_o,
    output logic                          wbm_stb_o,
    output logic                          wbm_cyc_o,
    input  logic                          wbm_err_i,
    input  logic                          wbm_ack_i,
    input  logic [nor_pkg::data_bits-1:0] wbm_dat_i,
    input  logic                          wbm_stall_i
);

    logic                          mod_reset;
    logic                          cmd_err;
    logic                          start;
    logic                          bus_go;
    logic                          bus_done;
    logic [nor_pkg::data_bits-1:0] bus_rdata;
    nor_pkg::nor_req_t             req;
    nor_pkg::nor_bus_req_t         bus_req;

    // dropped cyc or any error aborts the whole command
    assign mod_reset = wb_rst_i || !wbs_cyc_i || wbs_err_o;
    assign wbs_err_o = cmd_err || wbm_err_i;

    nor_req_latch req_latch_i (
        .wb_clk_i    (wb_clk_i),
        .mod_reset_i (mod_reset),
        .stb_i       (wbs_stb_i),
        .cmd_i       (wbs_adr_i),
        .data_i      (wbs_dat_i),
        .done_i      (wbs_ack_o),
        .req_o       (req),
        .start_o     (start),
        .stall_o     (wbs_stall_o),
        .cmd_err_o   (cmd_err)
    );

    // done doubles as the slave ack
    nor_cycle_sequencer sequencer_i (
        .wb_clk_i    (wb_clk_i),
        .mod_reset_i (mod_reset),
        .req_i       (req),
        .start_i     (start),
        .bus_done_i  (bus_done),
        .bus_rdata_i (bus_rdata),
        .bus_go_o    (bus_go),
        .bus_req_o   (bus_req),
        .done_o      (wbs_ack_o),
        .rdata_o     (wbs_dat_o)
    );

    nor_bus_master bus_master_i (
        .wb_clk_i    (wb_clk_i),
        .mod_reset_i (mod_reset),
        .go_i        (bus_go),
        .req_i       (bus_req),
        .wbm_ack_i   (wbm_ack_i),
        .wbm_dat_i   (wbm_dat_i),
        .wbm_stall_i (wbm_stall_i),
        .wbm_adr_o   (wbm_adr_o),
        .wbm_dat_o   (wbm_dat_o),
        .wbm_we_o    (wbm_we_o),
        .wbm_stb_o   (wbm_stb_o),
        .wbm_cyc_o   (wbm_cyc_o),
        .done_o      (bus_done),
        .rdata_o     (bus_rdata)
    );

endmodule

// File: src/nor_req_latch.sv
`timescale 1ns/1ns

module nor_req_latch (
    input  logic                             wb_clk_i,
    input  logic                             mod_reset_i,
    input  logic                             stb_i,
    input  nor_pkg::nor_cmd_t                cmd_i,
    input  logic [nor_pkg::data_bits-1:0]    data_i,
    input  logic                             done_i,
    output nor_pkg::nor_req_t                req_o,
    output logic                             start_o,
    output logic                             stall_o,
    output logic                             cmd_err_o
);

    logic req_valid;
    logic accept;
    logic cmd_ok;

    // one command in flight, so stall whenever something is held
    assign accept  = stb_i && !req_valid;
    assign stall_o = req_valid;

    // code check on the incoming word, for the start pulse
    assign cmd_ok = cmd_i.code <= nor_pkg::cmd_max_valid;

    // held code out of range; top turns this into err and mod_reset
    assign cmd_err_o = req_valid && (req_o.cmd.code > nor_pkg::cmd_max_valid);

    always_ff @(posedge wb_clk_i) begin
        if (mod_reset_i) begin
            req_valid <= 1'b0;
            start_o   <= 1'b0;
        end else begin
            // start only for a valid code, one cycle after accept
            start_o <= accept && cmd_ok;
            if (accept) begin
                req_valid <= 1'b1;
            end else if (done_i) begin
                req_valid <= 1'b0;
            end
        end
    end

    // payload
    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            req_o <= {cmd_i, data_i};
        end
    end

    // held request must not move until the sequencer is done with it
    a_hold_until_done : assert property (@(posedge wb_clk_i) disable iff (mod_reset_i)
        stall_o && !done_i |=> stall_o && $stable(req_o));

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic wb_clk_o,
    output logic rst_o
);

    // 4 ns period
    initial begin
        wb_clk_o = 1'b0;
        forever #2 wb_clk_o = ~wb_clk_o;
    end

    // reset held for two rising edges, released just after the second
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge wb_clk_o);
        #1 rst_o = 1'b0;
    end

endmodule

// File: test/tb_nor_controller.sv
`timescale 1ns/1ns

module tb_nor_controller;

    localparam int cycle_limit = 3000;

    logic wb_clk;
    logic rst;
    nor_pkg::nor_cmd_t wbs_adr;
    logic [15:0] wbs_dat_i, wbs_dat_o, wbm_dat_o, wbm_dat;
    logic [25:0] wbm_adr_o;
    logic wbs_we, wbs_stb, wbs_cyc, wbs_err_o, wbs_ack_o, wbs_stall_o;
    logic wbm_we_o, wbm_stb_o, wbm_cyc_o, wbm_err, wbm_ack, wbm_stall;

    // memory model state
    logic [15:0] mem [0:63];
    logic [31:0] mem_rng, stim_rng;
    logic ack_pending, inject_err, nxt_ack, nxt_err, nxt_stall;
    logic [1:0] ack_wait;
    logic [15:0] rd_word;
    nor_pkg::nor_bus_req_t entry;
    nor_pkg::nor_bus_req_t bus_log [$];
    nor_pkg::nor_bus_req_t exp_log [$];
    // slave command in flight is a read
    logic reading;
    int errors;
    int cycles;

    tb_clock_gen clock_gen_i (.wb_clk_o(wb_clk), .rst_o(rst));

    nor_controller nor_controller_i (
        .wb_clk_i(wb_clk), .wb_rst_i(rst),
        .wbs_adr_i(wbs_adr), .wbs_dat_i(wbs_dat_i), .wbs_we_i(wbs_we),
        .wbs_stb_i(wbs_stb), .wbs_cyc_i(wbs_cyc),
        .wbs_err_o(wbs_err_o), .wbs_ack_o(wbs_ack_o), .wbs_dat_o(wbs_dat_o),
        .wbs_stall_o(wbs_stall_o),
        .wbm_adr_o(wbm_adr_o), .wbm_dat_o(wbm_dat_o), .wbm_we_o(wbm_we_o),
        .wbm_stb_o(wbm_stb_o), .wbm_cyc_o(wbm_cyc_o),
        .wbm_err_i(wbm_err), .wbm_ack_i(wbm_ack), .wbm_dat_i(wbm_dat),
        .wbm_stall_i(wbm_stall)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // flash side: random stall, ack after 0..3 cycles, optional err instead of ack
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 16'hA500 | 16'(i * 5);
        end
        mem_rng = 32'h3438;
        ack_pending = 1'b0;
        ack_wait = '0;
        rd_word = '0;
        wbm_ack = 1'b0;
        wbm_err = 1'b0;
        wbm_stall = 1'b0;
        wbm_dat = '0;
        forever begin
            @(negedge wb_clk);
            nxt_ack = 1'b0;
            nxt_err = 1'b0;
            mem_rng = lcg_next(mem_rng);
            nxt_stall = mem_rng[17:16] == 2'b00;
            if (!wbm_cyc_o) begin
                ack_pending = 1'b0;
            end
            if (wbm_stb_o) begin
                entry.adr = wbm_adr_o;
                entry.we = wbm_we_o;
                entry.dat = wbm_we_o ? wbm_dat_o : 16'h0;
                bus_log.push_back(entry);
                if (wbm_we_o) begin
                    mem[wbm_adr_o[5:0]] = wbm_dat_o;
                end
                if (inject_err) begin
                    nxt_err = 1'b1;
                    inject_err = 1'b0;
                end else begin
                    ack_pending = 1'b1;
                    ack_wait = mem_rng[21:20];
                    rd_word = mem[wbm_adr_o[5:0]];
                end
            end
            if (ack_pending) begin
                if (ack_wait == 2'd0) begin
                    nxt_ack = 1'b1;
                    ack_pending = 1'b0;
                end else begin
                    ack_wait = ack_wait - 2'd1;
                end
            end
            @(posedge wb_clk);
            #1;
            wbm_ack = nxt_ack;
            wbm_err = nxt_err;
            wbm_stall = nxt_stall;
            wbm_dat = nxt_ack ? rd_word : 16'h0;
        end
    end

    // bus outputs frozen while a request waits on stall
    a_stall_hold : assert property (@(posedge wb_clk)
        disable iff (rst || nor_controller_i.mod_reset)
        nor_controller_i.bus_master_i.pending && wbm_stall
        |=> $stable(wbm_adr_o) && $stable(wbm_dat_o) && $stable(wbm_we_o))
        else begin
            errors++;
            $display("Mismatch wbm_adr_o/wbm_dat_o/wbm_we_o moved under stall: %h %h %h",
                     wbm_adr_o, wbm_dat_o, wbm_we_o);
        end

    // stall from acceptance until the cycle after ack
    a_stall_on_accept : assert property (@(posedge wb_clk) disable iff (rst || !wbs_cyc)
        wbs_stb && !wbs_stall_o && !wbs_err_o |=> wbs_stall_o)
        else begin
            errors++;
            $display("Mismatch wbs_stall_o after accept: %h expected 1", wbs_stall_o);
        end
    a_stall_held : assert property (@(posedge wb_clk) disable iff (rst || !wbs_cyc)
        wbs_stall_o && !wbs_ack_o && !wbs_err_o |=> wbs_stall_o)
        else begin
            errors++;
            $display("Mismatch wbs_stall_o dropped before ack: %h expected 1", wbs_stall_o);
        end
    a_stall_release : assert property (@(posedge wb_clk) disable iff (rst || !wbs_cyc)
        wbs_ack_o |=> !wbs_stall_o)
        else begin
            errors++;
            $display("Mismatch wbs_stall_o after ack: %h expected 0", wbs_stall_o);
        end

    // any error aborts: err for one cycle, then bus idle, no ack
    a_err_abort : assert property (@(posedge wb_clk) disable iff (rst)
        wbs_err_o |=> !wbm_cyc_o && !wbs_stall_o && !wbs_ack_o && !wbs_err_o)
        else begin
            errors++;
            $display("Mismatch after wbs_err_o: cyc %h stall %h ack %h err %h",
                     wbm_cyc_o, wbs_stall_o, wbs_ack_o, wbs_err_o);
        end
    a_master_err : assert property (@(posedge wb_clk) disable iff (rst)
        wbm_err |-> wbs_err_o)
        else begin
            errors++;
            $display("Mismatch wbs_err_o on wbm_err_i: %h expected 1", wbs_err_o);
        end

    // read data only moves together with the ack of a read
    a_rdata_on_ack : assert property (@(posedge wb_clk) disable iff (rst)
        !$stable(wbs_dat_o) |-> wbs_ack_o && reading)
        else begin
            errors++;
            $display("Mismatch wbs_dat_o changed without a read ack: %h ack %h read %h",
                     wbs_dat_o, wbs_ack_o, reading);
        end

    // run limit, about 20 commands x 6 bus cycles x 10 clocks plus margin
    always @(posedge wb_clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: no finish after %0d cycles, errors: %0d", cycles, errors + 1);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic add_word(input logic we, input logic [25:0] adr, input logic [15:0] dat);
        nor_pkg::nor_bus_req_t w;
        w.adr = adr;
        w.dat = dat;
        w.we = we;
        exp_log.push_back(w);
    endtask

    // expected flash words per command code
    task automatic build_expected(input logic [5:0] code, input logic [25:0] addr,
                                  input logic [15:0] data);
        exp_log.delete();
        case (code)
            6'd0: add_word(1'b0, addr, 16'h0);
            6'd1: add_word(1'b1, 26'h055, 16'h0098);
            6'd2: begin
                add_word(1'b1, 26'h555, 16'h00AA);
                add_word(1'b1, 26'h2AA, 16'h0055);
                add_word(1'b1, 26'h555, 16'h00A0);
                add_word(1'b1, addr, data);
            end
            6'd3, 6'd4: begin
                add_word(1'b1, 26'h555, 16'h00AA);
                add_word(1'b1, 26'h2AA, 16'h0055);
                add_word(1'b1, 26'h555, 16'h0080);
                add_word(1'b1, 26'h555, 16'h00AA);
                add_word(1'b1, 26'h2AA, 16'h0055);
                if (code == 6'd3) begin
                    add_word(1'b1, addr, 16'h0030);
                end else begin
                    add_word(1'b1, 26'h555, 16'h0010);
                end
            end
            6'd5: add_word(1'b1, 26'h000, 16'h00F0);
            default: ;
        endcase
    endtask

    // one slave request: present, wait for accept, then wait for ack or err
    task automatic run_cmd(input logic [5:0] code, input logic [25:0] addr,
                           input logic [15:0] data, output logic got_ack,
                           output logic got_err, output logic [15:0] rdata);
        logic fin;
        bus_log.delete();
        got_ack = 1'b0;
        got_err = 1'b0;
        rdata = '0;
        @(posedge wb_clk);
        #1;
        wbs_adr.code = code;
        wbs_adr.addr = addr;
        wbs_dat_i = data;
        wbs_stb = 1'b1;
        reading = code == 6'd0;
        fin = 1'b0;
        while (!fin) begin
            @(negedge wb_clk);
            fin = !wbs_stall_o;
        end
        @(posedge wb_clk);
        #1;
        wbs_stb = 1'b0;
        fin = 1'b0;
        while (!fin) begin
            @(negedge wb_clk);
            if (wbs_ack_o) begin
                got_ack = 1'b1;
                rdata = wbs_dat_o;
                fin = 1'b1;
            end else if (wbs_err_o) begin
                got_err = 1'b1;
                fin = 1'b1;
            end
        end
        // let stall fall before the next request
        @(negedge wb_clk);
    endtask

    task automatic exercise(input logic [5:0] code, input logic [25:0] addr,
                            input logic [15:0] data, input logic want_ack);
        logic got_ack, got_err;
        logic [15:0] rdata;
        build_expected(code, addr, data);
        // an injected err cuts the sequence after its first word
        while (!want_ack && exp_log.size() > 1) begin
            void'(exp_log.pop_back());
        end
        run_cmd(code, addr, data, got_ack, got_err, rdata);
        a_ack : assert (got_ack == want_ack && got_err == !want_ack) else begin
            errors++;
            $display("Mismatch wbs_ack_o/wbs_err_o code %h: got %h/%h expected %h/%h",
                     code, got_ack, got_err, want_ack, !want_ack);
        end
        a_count : assert (bus_log.size() == exp_log.size()) else begin
            errors++;
            $display("Mismatch master cycle count code %h: got %h expected %h",
                     code, bus_log.size(), exp_log.size());
        end
        for (int i = 0; i < exp_log.size() && i < bus_log.size(); i++) begin
            a_word : assert (bus_log[i] == exp_log[i]) else begin
                errors++;
                $display("Mismatch wbm adr/dat/we cycle %0d: got %h/%h/%h expected %h/%h/%h",
                         i, bus_log[i].adr, bus_log[i].dat, bus_log[i].we,
                         exp_log[i].adr, exp_log[i].dat, exp_log[i].we);
            end
        end
        if (code == 6'd0 && got_ack) begin
            a_rdata : assert (rdata == data) else begin
                errors++;
                $display("Mismatch wbs_dat_o: got %h expected %h", rdata, data);
            end
        end
    endtask

    initial begin
        logic [25:0] a;
        logic [15:0] d;
        errors = 0;
        inject_err = 1'b0;
        reading = 1'b0;
        stim_rng = 32'h3438;
        wbs_adr = '0;
        wbs_dat_i = '0;
        wbs_we = 1'b0;
        wbs_stb = 1'b0;
        wbs_cyc = 1'b1;
        @(negedge rst);
        // program then read back
        for (int k = 0; k < 4; k++) begin
            stim_rng = lcg_next(stim_rng);
            a = stim_rng[31:6];
            stim_rng = lcg_next(stim_rng);
            d = stim_rng[31:16];
            exercise(6'd2, a, d, 1'b1);
            exercise(6'd0, a, d, 1'b1);
        end
        exercise(6'd1, 26'h0, 16'h0, 1'b1);
        exercise(6'd5, 26'h0, 16'h0, 1'b1);
        exercise(6'd3, 26'h01A_3000, 16'h0, 1'b1);
        exercise(6'd4, 26'h0, 16'h0, 1'b1);
        // out-of-range codes
        exercise(6'd6, 26'h123, 16'h4567, 1'b0);
        exercise(6'd63, 26'h3FF_FFFF, 16'hFFFF, 1'b0);
        // flash err on the first strobe of a program
        inject_err = 1'b1;
        exercise(6'd2, 26'h0000_0040, 16'hBEEF, 1'b0);
        // recovers afterwards
        exercise(6'd2, 26'h0000_0077, 16'h1234, 1'b1);
        exercise(6'd0, 26'h0000_0077, 16'h1234, 1'b1);
        repeat (2) @(posedge wb_clk);
        $display("checks complete, errors: %0d, cycles: %0d", errors, cycles);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
